// File: afifo_pkg.sv
package afifo_pkg;

  parameter int def_data_width = 8;
  parameter int def_fifo_depth = 16; // power of two.
  parameter int ptr_max_w      = 16;

  function automatic logic [ptr_max_w-1:0] bin2gray(input logic [ptr_max_w-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [ptr_max_w-1:0] gray2bin(input logic [ptr_max_w-1:0] gray);
    logic [ptr_max_w-1:0] bin;
    bin[ptr_max_w-1] = gray[ptr_max_w-1];
    for (int i = ptr_max_w - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // running xor from the msb down.
    end
    return bin;
  endfunction

endpackage

// File: afifo_ram_if.sv
`timescale 1ns/1ps

interface afifo_ram_if #(
  parameter int data_width = 8,
  parameter int addr_width = 4
);

  logic                  we;
  logic [addr_width-1:0] waddr;
  logic [data_width-1:0] wdata;
  logic                  re;
  logic [addr_width-1:0] raddr;
  logic [data_width-1:0] rdata;

  modport wr_mp (
    output we,
    output waddr
  );

  modport rd_mp (
    output re,
    output raddr
  );

  modport mem_mp (
    input  we,
    input  waddr,
    input  wdata,
    input  re,
    input  raddr,
    output rdata
  );

endinterface

// File: afifo_dpram.sv
`timescale 1ns/1ps

module afifo_dpram #(
  parameter int data_width = 8,
  parameter int fifo_depth = 16
) (
  input logic          wr_clk,
  input logic          rd_clk,
  input logic          rd_rst_n,
  afifo_ram_if.mem_mp  ram
);

  localparam int addr_width = $clog2(fifo_depth);

  logic [data_width-1:0] mem [0:(1 << addr_width)-1];

  always_ff @(posedge wr_clk) begin
    if (ram.we) begin
      mem[ram.waddr] <= ram.wdata;
    end
  end

  // registered read port, holds its value between reads.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      ram.rdata <= '0;
    end else if (ram.re) begin
      ram.rdata <= mem[ram.raddr];
    end
  end

endmodule

// File: afifo_ptr_sync.sv
`timescale 1ns/1ps

module afifo_ptr_sync import afifo_pkg::*; #(
  parameter int ptr_w = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [ptr_w-1:0] ptr_gray,
  output logic [ptr_w-1:0] ptr_bin
);

  logic [ptr_w-1:0]     sync_q1;
  logic [ptr_w-1:0]     sync_q2;
  logic [ptr_max_w-1:0] bin_wide;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= ptr_gray; // first stage may go metastable.
      sync_q2 <= sync_q1;
    end
  end

  assign bin_wide = gray2bin(ptr_max_w'(sync_q2));
  assign ptr_bin  = bin_wide[ptr_w-1:0];

endmodule

// File: afifo_wr_ctrl.sv
`timescale 1ns/1ps

module afifo_wr_ctrl import afifo_pkg::*; #(
  parameter int fifo_depth = 16,
  parameter int fifo_afull = fifo_depth - 1
) (
  input  logic                              wr_clk,
  input  logic                              wr_rst_n,
  input  logic                              wr_en,
  input  logic [$clog2(fifo_depth):0]       rd_ptr_bin,
  output logic [$clog2(fifo_depth):0]       wr_ptr_gray,
  output logic                              full,
  output logic                              afull,
  afifo_ram_if.wr_mp                        ram
);

  localparam int addr_width = $clog2(fifo_depth);
  localparam int ptr_w      = addr_width + 1;

  logic                 wr_vld;
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     wr_ptr_nxt;
  logic [ptr_max_w-1:0] gray_nxt_wide;
  logic [ptr_w-1:0]     used_nxt;

  assign wr_vld     = wr_en & ~full; // writes while full are dropped.
  assign wr_ptr_nxt = wr_ptr + ptr_w'(wr_vld);

  assign gray_nxt_wide = bin2gray(ptr_max_w'(wr_ptr_nxt));

  // stale read pointer only overstates the fill level.
  assign used_nxt = wr_ptr_nxt - rd_ptr_bin;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= gray_nxt_wide[ptr_w-1:0]; // one bit flips per edge.
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (used_nxt == ptr_w'(fifo_depth));
      afull <= (used_nxt >= ptr_w'(fifo_afull));
    end
  end

  assign ram.we    = wr_vld;
  assign ram.waddr = wr_ptr[addr_width-1:0];

endmodule

// File: afifo_rd_ctrl.sv
`timescale 1ns/1ps

module afifo_rd_ctrl import afifo_pkg::*; #(
  parameter int fifo_depth  = 16,
  parameter int fifo_aempty = 1
) (
  input  logic                              rd_clk,
  input  logic                              rd_rst_n,
  input  logic                              rd_en,
  input  logic [$clog2(fifo_depth):0]       wr_ptr_bin,
  output logic [$clog2(fifo_depth):0]       rd_ptr_gray,
  output logic                              empty,
  output logic                              aempty,
  afifo_ram_if.rd_mp                        ram
);

  localparam int addr_width = $clog2(fifo_depth);
  localparam int ptr_w      = addr_width + 1;

  logic                 rd_vld;
  logic [ptr_w-1:0]     rd_ptr;
  logic [ptr_w-1:0]     rd_ptr_nxt;
  logic [ptr_max_w-1:0] gray_nxt_wide;
  logic [ptr_w-1:0]     used_nxt;

  assign rd_vld     = rd_en & ~empty; // reads while empty are ignored.
  assign rd_ptr_nxt = rd_ptr + ptr_w'(rd_vld);

  assign gray_nxt_wide = bin2gray(ptr_max_w'(rd_ptr_nxt));

  // stale write pointer only understates the fill level.
  assign used_nxt = wr_ptr_bin - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= gray_nxt_wide[ptr_w-1:0];
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (wr_ptr_bin == rd_ptr_nxt);
      aempty <= (used_nxt <= ptr_w'(fifo_aempty));
    end
  end

  // ram samples this address on the same edge that advances rd_ptr.
  assign ram.re    = rd_vld;
  assign ram.raddr = rd_ptr[addr_width-1:0];

endmodule

// File: async_fifo.sv
`timescale 1ns/1ps

module async_fifo import afifo_pkg::*; #(
  parameter int data_width  = def_data_width,
  parameter int fifo_depth  = def_fifo_depth,
  parameter int fifo_afull  = fifo_depth - 1,
  parameter int fifo_aempty = 1
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [data_width-1:0] wr_data,
  output logic                  full,
  output logic                  afull,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [data_width-1:0] rd_data,
  output logic                  empty,
  output logic                  aempty
);

  localparam int addr_width = $clog2(fifo_depth);
  localparam int ptr_w      = addr_width + 1;

  logic [ptr_w-1:0] wr_ptr_gray;
  logic [ptr_w-1:0] rd_ptr_gray;
  logic [ptr_w-1:0] wr_ptr_bin_rs; // write pointer in rd_clk domain.
  logic [ptr_w-1:0] rd_ptr_bin_ws; // read pointer in wr_clk domain.

  afifo_ram_if #(
    .data_width(data_width),
    .addr_width(addr_width)
  ) ram ();

  assign ram.wdata = wr_data;
  assign rd_data   = ram.rdata;

  afifo_wr_ctrl #(
    .fifo_depth(fifo_depth),
    .fifo_afull(fifo_afull)
  ) wr_ctrl_i (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .wr_en      (wr_en),
    .rd_ptr_bin (rd_ptr_bin_ws),
    .wr_ptr_gray(wr_ptr_gray),
    .full       (full),
    .afull      (afull),
    .ram        (ram.wr_mp)
  );

  afifo_rd_ctrl #(
    .fifo_depth (fifo_depth),
    .fifo_aempty(fifo_aempty)
  ) rd_ctrl_i (
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .rd_en      (rd_en),
    .wr_ptr_bin (wr_ptr_bin_rs),
    .rd_ptr_gray(rd_ptr_gray),
    .empty      (empty),
    .aempty     (aempty),
    .ram        (ram.rd_mp)
  );

  afifo_ptr_sync #(
    .ptr_w(ptr_w)
  ) wr2rd_sync_i (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .ptr_gray(wr_ptr_gray),
    .ptr_bin (wr_ptr_bin_rs)
  );

  afifo_ptr_sync #(
    .ptr_w(ptr_w)
  ) rd2wr_sync_i (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .ptr_gray(rd_ptr_gray),
    .ptr_bin (rd_ptr_bin_ws)
  );

  afifo_dpram #(
    .data_width(data_width),
    .fifo_depth(fifo_depth)
  ) dpram_i (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .ram     (ram.mem_mp)
  );

endmodule

// File: tb_async_fifo.sv
`timescale 1ns/1ps

module tb_async_fifo;

  localparam int depth      = 16;
  localparam int max_cycles = 4000; // phases take about 1950 wr_clk cycles.

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  logic [7:0] wr_data;
  logic       full;
  logic       afull;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  logic [7:0] rd_data;
  logic       empty;
  logic       aempty;

  logic [31:0] lfsr;
  logic [7:0]  model_q[$];
  logic [7:0]  last_rd;
  logic [7:0]  exp_rd;
  logic        rd_acc;
  logic        wr_run;
  logic        rd_run;
  int          wr_prob;
  int          rd_prob;
  int          wr_count;
  int          fill_start;
  int          cycle_count;
  int          checks;
  int          errors;

  async_fifo async_fifo_i (
    .wr_clk  (wr_clk),
    .wr_rst_n(wr_rst_n),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .full    (full),
    .afull   (afull),
    .rd_clk  (rd_clk),
    .rd_rst_n(rd_rst_n),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty),
    .aempty  (aempty)
  );

  always #20 wr_clk = ~wr_clk;
  always #28 rd_clk = ~rd_clk; // starts high, so its edges never meet wr_clk edges.

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1.
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s actual 0x%0h expected 0x%0h at %0t", name, actual, expected,
               $time);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  task automatic check_reset_values();
    check_value("full", 32'(full), 32'h0);
    check_value("afull", 32'(afull), 32'h0);
    check_value("empty", 32'(empty), 32'h1);
    check_value("aempty", 32'(aempty), 32'h1);
    check_value("rd_data", 32'(rd_data), 32'h0);
  endtask

  task automatic check_flags();
    int cnt;
    cnt = model_q.size();
    check_value("full", 32'(full), 32'(cnt == depth));
    check_value("empty", 32'(empty), 32'(cnt == 0));
    check_value("afull", 32'(afull), 32'(cnt >= depth - 1));
    check_value("aempty", 32'(aempty), 32'(cnt <= 1));
  endtask

  task automatic settle_and_check();
    wr_run = 1'b0;
    rd_run = 1'b0;
    repeat (10) @(posedge rd_clk); // at least 8 idle cycles on each side.
    #5;
    check_flags();
  endtask

  task automatic run_phase(input int wp, input int rp, input int cycles);
    wr_prob = wp;
    rd_prob = rp;
    wr_run  = 1'b1;
    rd_run  = 1'b1;
    repeat (cycles) @(posedge wr_clk);
    settle_and_check();
  endtask

  // write side model, then the next drive.
  always @(posedge wr_clk) begin
    if (wr_en && !full) begin
      model_q.push_back(wr_data);
      wr_count++;
      if (model_q.size() > depth) begin
        report_error("model holds more words than the fifo depth");
      end
    end
    #2;
    wr_en   = wr_run && (take_bits(4) < wr_prob);
    wr_data = 8'(take_bits(8));
  end

  always @(posedge rd_clk) begin
    rd_acc = rd_en && !empty;
    if (rd_rst_n && !empty && model_q.size() == 0) begin
      report_error("empty is low while the model queue holds no word");
    end
    #2;
    if (rd_acc) begin
      if (model_q.size() == 0) begin
        report_error("read accepted with no word written");
      end else begin
        exp_rd  = model_q.pop_front();
        last_rd = exp_rd;
      end
    end
    if (rd_rst_n) begin
      check_value("rd_data", 32'(rd_data), 32'(last_rd)); // a refused read keeps the old word.
    end
    rd_en = rd_run && (take_bits(4) < rd_prob);
  end

  always @(posedge wr_clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d wr_clk cycles, the run did not finish", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    wr_clk      = 1'b0;
    rd_clk      = 1'b1;
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    wr_en       = 1'b0;
    wr_data     = 8'h00;
    rd_en       = 1'b0;
    lfsr        = 32'he9387121;
    last_rd     = 8'h00;
    exp_rd      = 8'h00;
    rd_acc      = 1'b0;
    wr_run      = 1'b0;
    rd_run      = 1'b0;
    wr_prob     = 0;
    rd_prob     = 0;
    wr_count    = 0;
    fill_start  = 0;
    cycle_count = 0;
    checks      = 0;
    errors      = 0;

    repeat (8) @(posedge wr_clk);
    #5;
    check_reset_values();
    repeat (8) @(posedge wr_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    repeat (2) @(posedge wr_clk);
    #5;
    check_reset_values();

    run_phase(8, 11, 600);  // balanced, rd_clk is 1.4 times slower.
    run_phase(14, 6, 600);  // write-heavy, runs into full.
    run_phase(4, 14, 600);  // read-heavy, many reads while empty.

    // drain everything, then fill from empty with reads stopped.
    wr_prob = 0;
    rd_prob = 16;
    rd_run  = 1'b1;
    do begin
      @(posedge rd_clk);
      #5;
    end while (model_q.size() != 0);
    settle_and_check();

    fill_start = wr_count;
    wr_prob    = 16;
    wr_run     = 1'b1;
    do begin
      @(posedge wr_clk);
      #5;
    end while (!full);
    check_value("fill_count", 32'(wr_count - fill_start), 32'(depth));
    settle_and_check();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
afifo_pkg.sv
afifo_ram_if.sv
afifo_dpram.sv
afifo_ptr_sync.sv
afifo_wr_ctrl.sv
afifo_rd_ctrl.sv
async_fifo.sv
tb_async_fifo.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing -f vlog.f --top-module tb_async_fifo -o sim_async_fifo \
  && ./obj_dir/sim_async_fifo | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
